// File: logic/hyperRamBeatTimer.sv
/* Beat and latency counters plus the gated memory clock
   Feeds phase-end flags back to the sequencer
*/
`timescale 1ns/1ps

module hyperRamBeatTimer (
	input  logic                               iCLK,
	input  logic                               iRST,
	input  hyperRamPkg::hyperRamStateE         state,
	input  logic [hyperRamPkg::lpLatWidth-1:0] latencyCnt,
	output logic                               caLast,    // Last CA beat this cycle
	output logic                               latDone,   // Latency wait ends this cycle
	output logic                               latSkip,   // No latency phase
	output logic                               memClk
);
	import hyperRamPkg::*;

	logic [lpCaCntWidth-1:0] cmdCnt;   // CA beat index
	logic [lpLatWidth-1:0]   latCnt;   // Latency cycles so far
	logic                    clkEn;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			cmdCnt <= '0;
			latCnt <= '0;
		end
		else
		begin
			cmdCnt <= (state == stCmdAdrs) ? cmdCnt + 1'b1 : '0;   // Clears outside CA phase
			latCnt <= (state == stLatency && !latDone) ? latCnt + 1'b1 : '0;   // Stops at request
		end
	end

	assign caLast  = (state == stCmdAdrs) && (cmdCnt == lpCaCntWidth'(lpCaBeats - 1));
	assign latDone = (state == stLatency) && (latCnt == latencyCnt);   // L+1 wait cycles
	assign latSkip = (latencyCnt == '0);

	// Clock runs from the CA phase to the end of the access
	assign clkEn = state inside {stCmdAdrs, stLatency, stDqSeq1, stDqSeq2, stComplete};

	// Toggle mid-cycle so each edge is centered on stable DQ
	always_ff @(negedge iCLK)
	begin
		if (iRST)
			memClk <= 1'b0;
		else if (clkEn)
			memClk <= ~memClk;
		else
			memClk <= 1'b0;   // Parked low between accesses
	end

	// Sequencer leaves stLatency before the counter overruns the request
	latBound: assert property (@(posedge iCLK) disable iff (iRST)
		latCnt <= latencyCnt);

endmodule

// File: logic/hyperRamDqShifter.sv
/* Output side of the HyperBus: CA bytes, write word and the DQ enable
   The pad tristate is built outside from memDq and memDqOe
*/
`timescale 1ns/1ps

module hyperRamDqShifter (
	input  logic                               iCLK,
	input  logic                               iRST,
	input  hyperRamPkg::hyperRamStateE         state,
	input  hyperRamPkg::hyperRamAccessE        access,
	input  logic [hyperRamPkg::lpCaWidth-1:0]  caWord,
	input  logic [hyperRamPkg::lpRegWidth-1:0] wrData,
	output logic [hyperRamPkg::lpDqWidth-1:0]  memDq,
	output logic                               memDqOe,
	output logic                               memRwds,
	output logic                               memRwdsOe
);
	import hyperRamPkg::*;

	// CA word followed by the write word, top byte on the bus
	logic [lpCaWidth+lpRegWidth-1:0] shiftReg;
	logic                            dqOeReg;   // Enable window from RwdsPrep to DqSeq2

	always_ff @(posedge iCLK)
	begin
		case (state)
			stIdle:
				shiftReg <= {caWord, wrData};   // Captured on the start edge
			stCmdAdrs, stDqSeq1:
				shiftReg <= {shiftReg[lpCaWidth+lpRegWidth-lpDqWidth-1:0],
					shiftReg[lpCaWidth+lpRegWidth-1 -: lpDqWidth]};   // Next byte up
			default:
				shiftReg <= shiftReg;   // Hold through latency and completion
		endcase
	end

	assign memDq = shiftReg[lpCaWidth+lpRegWidth-1 -: lpDqWidth];   // MSB byte first

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			dqOeReg <= 1'b0;
		else if (state == stRwdsPrep)
			dqOeReg <= 1'b1;                       // Drive from first CA beat
		else if (state inside {stIdle, stDqSeq2, stComplete})
			dqOeReg <= 1'b0;
	end

	// Reads release DQ right after the last CA beat
	assign memDqOe = dqOeReg && ((state == stCmdAdrs) || (access == accWrite));

	// Register writes carry no byte mask, RWDS stays with the device
	assign memRwds   = 1'b0;
	assign memRwdsOe = 1'b0;

	// Bus released by the time the sequencer is back in idle
	dqIdleOff: assert property (@(posedge iCLK) disable iff (iRST)
		(state == stIdle) |-> !memDqOe);

endmodule

// File: logic/hyperRamPkg.sv
/* Shared widths, state encoding and access commands for the HyperRAM register path
   Imported by every module of the register-access subsystem
*/
package hyperRamPkg;

	// Bus and word widths
	localparam int lpDqWidth  = 8;               // One HyperBus byte
	localparam int lpRegWidth = 16;              // ID / config register word
	localparam int lpCaWidth  = 48;              // Command/address word
	localparam int lpLatWidth = 4;               // Latency count from caller

	// Command/address phase
	localparam int lpCaBeats    = 6;                  // CA bytes per access
	localparam int lpCaCntWidth = $clog2(lpCaBeats);  // Beat counter width

	// Sequencer states, ordered so that the clocked phase is contiguous
	typedef enum logic [2:0]
	{
		stIdle     = 3'd0,   // Waiting for start level
		stCsAssert = 3'd1,   // CS goes low at end
		stRwdsPrep = 3'd2,   // DQ enable turns on at end
		stCmdAdrs  = 3'd3,   // Six CA beats
		stLatency  = 3'd4,   // Optional latency wait
		stDqSeq1   = 3'd5,   // High data byte
		stDqSeq2   = 3'd6,   // Low data byte
		stComplete = 3'd7    // Done held until start drops
	} hyperRamStateE;

	// Register access direction
	// Kept apart from the R/W# bit inside the CA word
	typedef enum logic
	{
		accRead  = 1'b0,
		accWrite = 1'b1
	} hyperRamAccessE;

endpackage

// File: logic/hyperRamReadCapture.sv
/* Register read capture
   RWDS high loads the upper byte, RWDS low the lower one, frozen while done is high
*/
`timescale 1ns/1ps

module hyperRamReadCapture (
	input  logic                               iCLK,
	input  logic [hyperRamPkg::lpDqWidth-1:0]  memDqIn,     // DQ as seen at the pads
	input  logic                               memRwdsIn,   // Byte steering from device
	input  logic                               done,
	output logic [hyperRamPkg::lpRegWidth-1:0] capData
);
	import hyperRamPkg::*;

	// Loads every cycle of an access
	// Only the last high and last low beats survive to done
	always_ff @(posedge iCLK)
	begin
		if (!done)
		begin
			if (memRwdsIn)
				capData[lpRegWidth-1 -: lpDqWidth] <= memDqIn;   // First data beat
			else
				capData[lpDqWidth-1:0] <= memDqIn;               // Second data beat
		end
	end

endmodule

// File: logic/hyperRamRegAccess.sv
/* Top of the HyperRAM register-access path
   Caller drives start, CA word, write word and latency; pads sit outside
*/
`timescale 1ns/1ps

module hyperRamRegAccess (
	input  logic                               iCLK,
	input  logic                               iRST,
	// Caller side
	input  logic                               seqEn,        // Start level
	input  hyperRamPkg::hyperRamAccessE        access,
	input  logic [hyperRamPkg::lpCaWidth-1:0]  caWord,
	input  logic [hyperRamPkg::lpRegWidth-1:0] wrData,
	input  logic [hyperRamPkg::lpLatWidth-1:0] latencyCnt,   // 0 skips the wait
	output logic                               done,
	output logic [hyperRamPkg::lpRegWidth-1:0] capData,      // Read word
	// HyperBus pad side
	output logic [hyperRamPkg::lpDqWidth-1:0]  memDq,
	output logic                               memDqOe,
	output logic                               memRwds,
	output logic                               memRwdsOe,
	output logic                               memClk,
	output logic                               memCs,
	input  logic [hyperRamPkg::lpDqWidth-1:0]  memDqIn,
	input  logic                               memRwdsIn
);
	import hyperRamPkg::*;

	hyperRamStateE state;
	logic          caLast;
	logic          latDone;
	logic          latSkip;

	hyperRamRegFsm fsm_i (
		.iCLK    (iCLK),
		.iRST    (iRST),
		.seqEn   (seqEn),
		.access  (access),
		.caLast  (caLast),
		.latDone (latDone),
		.latSkip (latSkip),
		.state   (state),
		.memCs   (memCs),
		.done    (done)
	);

	hyperRamBeatTimer timer_i (
		.iCLK       (iCLK),
		.iRST       (iRST),
		.state      (state),
		.latencyCnt (latencyCnt),
		.caLast     (caLast),
		.latDone    (latDone),
		.latSkip    (latSkip),
		.memClk     (memClk)
	);

	hyperRamDqShifter shifter_i (
		.iCLK      (iCLK),
		.iRST      (iRST),
		.state     (state),
		.access    (access),
		.caWord    (caWord),
		.wrData    (wrData),
		.memDq     (memDq),
		.memDqOe   (memDqOe),
		.memRwds   (memRwds),
		.memRwdsOe (memRwdsOe)
	);

	hyperRamReadCapture capture_i (
		.iCLK      (iCLK),
		.memDqIn   (memDqIn),
		.memRwdsIn (memRwdsIn),
		.done      (done),
		.capData   (capData)
	);

endmodule

// File: logic/hyperRamRegFsm.sv
/* Sequencer for one HyperBus register access
   Steps from chip select through CA, latency and data beats to a held done level
*/
`timescale 1ns/1ps

module hyperRamRegFsm (
	input  logic                        iCLK,
	input  logic                        iRST,
	input  logic                        seqEn,    // Start level, held until done
	input  hyperRamPkg::hyperRamAccessE access,   // Read or write select
	input  logic                        caLast,   // Sixth CA beat from timer
	input  logic                        latDone,  // Latency count reached
	input  logic                        latSkip,  // Zero latency requested
	output hyperRamPkg::hyperRamStateE  state,
	output logic                        memCs,    // Active-low chip select
	output logic                        done
);
	import hyperRamPkg::*;

	hyperRamStateE stateNext;

	// Next-state decode
	always_comb
	begin
		stateNext = state;
		case (state)
			stIdle:
			begin
				if (seqEn)
					stateNext = stCsAssert;
			end
			stCsAssert:
				stateNext = stRwdsPrep;
			stRwdsPrep:
				stateNext = stCmdAdrs;
			stCmdAdrs:
			begin
				if (caLast)
					stateNext = latSkip ? stDqSeq1 : stLatency;   // Bypass wait when L is 0
			end
			stLatency:
			begin
				if (latDone)
					stateNext = stDqSeq1;
			end
			stDqSeq1:
				stateNext = stDqSeq2;
			stDqSeq2:
				stateNext = stComplete;
			stComplete:
			begin
				if (!seqEn)
					stateNext = stIdle;   // Caller released start
			end
			default:
				stateNext = stIdle;
		endcase
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state <= stIdle;
			memCs <= 1'b1;   // Deselected
			done  <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			if (state == stCsAssert)
				memCs <= 1'b0;                 // Falls at end of stCsAssert
			else if (state == stDqSeq2)
				memCs <= 1'b1;                 // Rises as stComplete begins
			done  <= (state == stComplete);    // One cycle behind stComplete entry
		end
	end

	// Chip select never active while idle or completed
	csInAccess: assert property (@(posedge iCLK) disable iff (iRST)
		!memCs |-> !(state inside {stIdle, stComplete}));

	// Direction must not change while the device is selected
	accessHeld: assert property (@(posedge iCLK) disable iff (iRST)
		!memCs |-> $stable(access));

endmodule

// File: verification/hyperRamRegModel.sv
/* Behavioral HyperRAM register model for the register-access testbench
   Decodes CA beats on memClk edges, stores register writes and answers register reads
*/
`timescale 1ns/1ps

module hyperRamRegModel #(
	parameter logic [15:0] pId0 = 16'h0c81,   // Identification register 0
	parameter logic [15:0] pId1 = 16'h0001    // Identification register 1
) (
	input  logic                               memClk,
	input  logic                               memCs,       // Active low
	input  logic [hyperRamPkg::lpDqWidth-1:0]  memDq,       // Controller drive
	input  logic                               memDqOe,
	input  logic                               memRwds,
	input  logic                               memRwdsOe,
	input  logic [4:0]                         latBeats,    // Clock edges between CA and data
	output logic [hyperRamPkg::lpDqWidth-1:0]  dqIn,        // Resolved bus, back to controller
	output logic                               rwdsIn,
	output logic [hyperRamPkg::lpCaWidth-1:0]  lastCa       // CA word of the latest access
);
	import hyperRamPkg::*;

	logic [lpDqWidth-1:0]  devDq;              // Device side of DQ
	logic                  devRwds;
	logic [lpCaWidth-1:0]  caShift;            // CA bytes, first byte ends up on top
	logic [lpRegWidth-1:0] regFile [4];        // ID0, ID1, CR0, CR1
	logic [lpDqWidth-1:0]  wrHigh;             // First write beat
	logic [1:0]            regSel;
	int                    beatCnt;            // Clock edges since CS fell
	int                    dataBeat;

	// Controller wins the bus while it drives
	assign dqIn   = memDqOe ? memDq : devDq;
	assign rwdsIn = memRwdsOe ? memRwds : devRwds;

	initial
	begin
		regFile[0] = pId0;
		regFile[1] = pId1;
		regFile[2] = 16'h8f1f;   // CR0 power-up value
		regFile[3] = 16'hffc1;   // CR1 power-up value
		devDq      = '0;
		devRwds    = 1'b0;
		caShift    = '0;
		wrHigh     = '0;
		beatCnt    = 0;
		lastCa     = '0;
	end

	// Both clock edges are beats, DDR
	always @(memClk or posedge memCs)
	begin
		if (memCs !== 1'b0)
			beatCnt = 0;   // Deselected
		else
		begin
			if (beatCnt < lpCaBeats)
				caShift = {caShift[lpCaWidth-lpDqWidth-1:0], dqIn};
			else if (beatCnt >= lpCaBeats + latBeats)
			begin
				dataBeat = beatCnt - lpCaBeats - latBeats;
				regSel   = {caShift[24], caShift[0]};   // Upper address bit picks CR, lowest ID/CR index
				lastCa   = caShift;
				if (caShift[lpCaWidth-1])   // R/W# high, read
				begin
					if (dataBeat == 0)
					begin
						devDq   = regFile[regSel][15:8];
						devRwds = 1'b1;
					end
					else if (dataBeat == 1)
					begin
						devDq   = regFile[regSel][7:0];
						devRwds = 1'b0;   // Held after the access
					end
				end
				else if (dataBeat == 0)
					wrHigh = dqIn;
				else if (dataBeat == 1)
					regFile[regSel] = {wrHigh, dqIn};   // Write lands on the second beat
			end
			beatCnt = beatCnt + 1;
		end
	end

endmodule

// File: verification/tbHyperRamRegAccess.sv
/* Directed tests for the HyperRAM register-access path
   Runs the controller against the behavioral register model and checks timing and data
*/
`timescale 1ns/1ps

module tbHyperRamRegAccess;
	import hyperRamPkg::*;

	localparam logic [7:0]  lpCmdRead   = 8'hc0;   // Read, register space
	localparam logic [7:0]  lpCmdWrite  = 8'h60;   // Write, register space, linear burst
	localparam logic [39:0] lpAdrsId0   = 40'h00_0000_0000;
	localparam logic [39:0] lpAdrsCr0   = 40'h00_0100_0000;
	localparam logic [39:0] lpAdrsCr1   = 40'h00_0100_0001;
	localparam logic [15:0] lpId0Value  = 16'h0c81;
	localparam logic [31:0] lpSeed      = 32'h1d72c7f0;
	localparam int lpDoneLimit    = 40;                // Cycles allowed per wait
	localparam int lpAccessCount  = 7;
	localparam int lpAccessCycles = 12 + 15 + 10;      // Longest access, hold and release
	localparam int lpIdleCycles   = 40;                // Reset and idle checks
	localparam int lpWatchdogNs   = 2 * (lpAccessCount * lpAccessCycles + lpIdleCycles) * 10;

	logic                  iCLK = 1'b0;
	logic                  iRST;
	logic                  seqEn;
	hyperRamAccessE        access;
	logic [lpCaWidth-1:0]  caWord;
	logic [lpRegWidth-1:0] wrData;
	logic [lpLatWidth-1:0] latencyCnt;
	logic                  done;
	logic [lpRegWidth-1:0] capData;
	logic [lpDqWidth-1:0]  memDq;
	logic [lpDqWidth-1:0]  memDqIn;
	logic                  memDqOe;
	logic                  memRwds;
	logic                  memRwdsOe;
	logic                  memRwdsIn;
	logic                  memClk;
	logic                  memCs;
	logic [lpDqWidth-1:0]  modelDq;     // Resolved bus from the model
	logic                  modelRwds;
	logic                  disturb;     // Inverts the bus seen by the DUT
	logic [4:0]            latBeats;    // Model's view of the wait
	logic [lpCaWidth-1:0]  modelCa;
	int                    errCnt = 0;
	int                    testsRun = 0;
	int                    testsFailed = 0;
	int                    clkEdges = 0;
	int                    rwdsDriven = 0;
	int                    seedDummy;

	always #5 iCLK = ~iCLK;   // 10 ns

	always @(memClk)
		clkEdges++;

	// Selected cycles where the controller drives RWDS
	always @(negedge iCLK)
		if (memCs === 1'b0 && memRwdsOe !== 1'b0)
			rwdsDriven++;

	assign memDqIn   = disturb ? ~modelDq : modelDq;
	assign memRwdsIn = disturb ? ~modelRwds : modelRwds;

	hyperRamRegAccess dut_i (
		.iCLK       (iCLK),
		.iRST       (iRST),
		.seqEn      (seqEn),
		.access     (access),
		.caWord     (caWord),
		.wrData     (wrData),
		.latencyCnt (latencyCnt),
		.done       (done),
		.capData    (capData),
		.memDq      (memDq),
		.memDqOe    (memDqOe),
		.memRwds    (memRwds),
		.memRwdsOe  (memRwdsOe),
		.memClk     (memClk),
		.memCs      (memCs),
		.memDqIn    (memDqIn),
		.memRwdsIn  (memRwdsIn)
	);

	hyperRamRegModel #(.pId0(lpId0Value)) model_i (
		.memClk    (memClk),
		.memCs     (memCs),
		.memDq     (memDq),
		.memDqOe   (memDqOe),
		.memRwds   (memRwds),
		.memRwdsOe (memRwdsOe),
		.latBeats  (latBeats),
		.dqIn      (modelDq),
		.rwdsIn    (modelRwds),
		.lastCa    (modelCa)
	);

	task automatic checkVal(input string name, input logic [lpCaWidth-1:0] got,
		input logic [lpCaWidth-1:0] exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t ns: %s got 'h%0h, expected 'h%0h", $time, name, got, exp);
			errCnt++;
		end
	endtask

	task automatic reportTest(input string name, input int errsBefore);
		testsRun++;
		if (errCnt == errsBefore)
			$display("test %s: ok", name);
		else
		begin
			testsFailed++;
			$display("test %s: %0d error(s)", name, errCnt - errsBefore);
		end
	endtask

	// Start edge to done edge
	function automatic int doneDelay(input logic [lpLatWidth-1:0] lat);
		return (lat == 0) ? 11 : 12 + lat;
	endfunction

	// Cycles counted from the edge that samples seqEn
	task automatic startAccess(input hyperRamAccessE acc, input logic [lpCaWidth-1:0] ca,
		input logic [lpRegWidth-1:0] wd, input logic [lpLatWidth-1:0] lat, output int cycles);
		@(posedge iCLK);
		seqEn      <= 1'b1;
		access     <= acc;
		caWord     <= ca;
		wrData     <= wd;
		latencyCnt <= lat;
		latBeats   <= (lat == 0) ? 5'd0 : {1'b0, lat} + 5'd1;   // Wait lasts L+1 cycles
		@(posedge iCLK);   // seqEn sampled here
		cycles = 0;
		do
		begin
			@(posedge iCLK);
			cycles++;
			@(negedge iCLK);   // Outputs settled
		end
		while (!done && cycles < lpDoneLimit);
		if (!done)
		begin
			$display("done did not rise within %0d cycles of start at %0t ns", lpDoneLimit, $time);
			errCnt++;
		end
	endtask

	task automatic releaseStart();
		int waitCycles;
		@(posedge iCLK);
		seqEn <= 1'b0;
		waitCycles = 0;
		do
		begin
			@(posedge iCLK);
			waitCycles++;
			@(negedge iCLK);
		end
		while (done && waitCycles < lpDoneLimit);
		if (done)
		begin
			$display("done stayed high after start was released, at %0t ns", $time);
			errCnt++;
		end
	endtask

	task automatic idleClockAfterReset();
		int errsBefore;
		int edgesBefore;
		int cycles;
		errsBefore = errCnt;
		@(negedge iCLK);
		checkVal("memCs", memCs, 1);
		checkVal("memDqOe", memDqOe, 0);
		checkVal("memRwds", memRwds, 0);
		checkVal("memRwdsOe", memRwdsOe, 0);
		checkVal("memClk", memClk, 0);
		checkVal("done", done, 0);
		edgesBefore = clkEdges;
		repeat (4)
			@(negedge iCLK);
		checkVal("memClk edges while idle", clkEdges, edgesBefore);
		startAccess(accRead, {lpCmdRead, lpAdrsId0}, '0, 4'd0, cycles);
		checkVal("memClk running in access", (clkEdges - edgesBefore) >= 8, 1);   // 6 CA + 2 data
		releaseStart();
		repeat (2)
			@(negedge iCLK);
		edgesBefore = clkEdges;
		repeat (4)
			@(negedge iCLK);
		checkVal("memClk edges after access", clkEdges, edgesBefore);
		checkVal("memClk", memClk, 0);   // Parked low
		reportTest("resetState", errsBefore);
	endtask

	task automatic readIdZero();
		int errsBefore;
		int cycles;
		errsBefore = errCnt;
		startAccess(accRead, {lpCmdRead, lpAdrsId0}, '0, 4'd0, cycles);
		checkVal("capData", capData, lpId0Value);
		checkVal("done delay", cycles, doneDelay(4'd0));
		releaseStart();
		reportTest("readId0", errsBefore);
	endtask

	task automatic writeReadBack(input string name, input logic [39:0] adrs,
		input logic [lpLatWidth-1:0] lat);
		int errsBefore;
		int cycles;
		logic [lpRegWidth-1:0] value;
		errsBefore = errCnt;
		value = 16'($urandom);
		startAccess(accWrite, {lpCmdWrite, adrs}, value, lat, cycles);
		checkVal("model CA word (write)", modelCa, {lpCmdWrite, adrs});
		checkVal("done delay (write)", cycles, doneDelay(lat));
		checkVal("RWDS driven cycles", rwdsDriven, 0);   // Device keeps RWDS on writes
		releaseStart();
		startAccess(accRead, {lpCmdRead, adrs}, '0, lat, cycles);
		checkVal("model CA word (read)", modelCa, {lpCmdRead, adrs});
		checkVal("capData", capData, value);   // Read back what went out
		checkVal("done delay (read)", cycles, doneDelay(lat));
		releaseStart();
		reportTest(name, errsBefore);
	endtask

	task automatic holdDoneUntilRelease();
		int errsBefore;
		int cycles;
		logic [lpRegWidth-1:0] held;
		errsBefore = errCnt;
		startAccess(accRead, {lpCmdRead, lpAdrsId0}, '0, 4'd0, cycles);
		held = capData;
		@(posedge iCLK);
		disturb <= 1'b1;   // Bus changes under the frozen capture
		repeat (5)
		begin
			@(negedge iCLK);
			checkVal("done while held", done, 1);
			checkVal("capData while held", capData, held);
		end
		@(posedge iCLK);
		seqEn <= 1'b0;
		@(posedge iCLK);   // Release sampled, FSM back to idle
		@(negedge iCLK);
		checkVal("done at idle return", done, 1);
		checkVal("capData at idle return", capData, held);
		@(posedge iCLK);
		@(negedge iCLK);
		checkVal("done after release", done, 0);   // One cycle later
		checkVal("capData after release", capData, held);
		@(posedge iCLK);
		disturb <= 1'b0;
		reportTest("doneHold", errsBefore);
	endtask

	initial
	begin
		#(lpWatchdogNs);
		$display("watchdog expired after %0d ns, a test did not finish", lpWatchdogNs);
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		iRST       = 1'b1;
		seqEn      = 1'b0;
		access     = accRead;
		caWord     = '0;
		wrData     = '0;
		latencyCnt = '0;
		latBeats   = '0;
		disturb    = 1'b0;
		seedDummy  = $urandom(lpSeed);   // Seeds the generator once
		repeat (2)
			@(posedge iCLK);
		iRST <= 1'b0;
		idleClockAfterReset();
		readIdZero();
		writeReadBack("writeReadCr0", lpAdrsCr0, 4'd0);
		writeReadBack("latency6Cr1", lpAdrsCr1, 4'd6);
		holdDoneUntilRelease();
		$display("tests run %0d, failed %0d, check errors %0d", testsRun, testsFailed, errCnt);
		if (errCnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: vlog.f
logic/hyperRamPkg.sv
logic/hyperRamRegFsm.sv
logic/hyperRamBeatTimer.sv
logic/hyperRamDqShifter.sv
logic/hyperRamReadCapture.sv
logic/hyperRamRegAccess.sv
verification/hyperRamRegModel.sv
verification/tbHyperRamRegAccess.sv
